// ==== hw/led_pkg.sv ====
`default_nettype none

package led_pkg;

    localparam int NUM_CH  = 4;
    localparam int CH_W    = 2;
    localparam int COLOR_W = 24;
    localparam int NIB_W   = 4;
    localparam int FIELD_W = 4;

    // nibble field codes, red msb first
    localparam logic [FIELD_W-1:0] FIELD_RED_MSB = 4'd3;
    localparam logic [FIELD_W-1:0] FIELD_RED_LSB = 4'd4;
    localparam logic [FIELD_W-1:0] FIELD_GRN_MSB = 4'd5;
    localparam logic [FIELD_W-1:0] FIELD_GRN_LSB = 4'd6;
    localparam logic [FIELD_W-1:0] FIELD_BLU_MSB = 4'd7;
    localparam logic [FIELD_W-1:0] FIELD_BLU_LSB = 4'd8;

    // preset ring, in stepping order
    localparam logic [COLOR_W-1:0] PRESET_RED    = 24'hff_00_00;
    localparam logic [COLOR_W-1:0] PRESET_GREEN  = 24'h00_ff_00;
    localparam logic [COLOR_W-1:0] PRESET_BLUE   = 24'h00_00_ff;
    localparam logic [COLOR_W-1:0] PRESET_YELLOW = 24'hff_ff_00;

    localparam int PWM_W        = 8;
    localparam int PWM_PRESCALE = 1;
    localparam int PRESCALE_W   = (PWM_PRESCALE > 1) ? $clog2(PWM_PRESCALE) : 1;

    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // register map
    localparam logic [AXI_ADDR_W-1:0] REG_CMD    = 8'h00;
    localparam logic [AXI_ADDR_W-1:0] REG_STEP   = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_COLOR0 = 8'h10;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== hw/pwm_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_timer import led_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    output logic [PWM_W-1:0] ramp,
    output logic             period_start
);

    logic [PRESCALE_W-1:0] pre_cnt;
    logic                  step;

    assign step = (32'(pre_cnt) == PWM_PRESCALE - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre_cnt <= '0;
            ramp    <= '0;
        end else if (step) begin
            pre_cnt <= '0;
            // wraps after 256 steps
            ramp    <= ramp + PWM_W'(1);
        end else begin
            pre_cnt <= pre_cnt + PRESCALE_W'(1);
        end
    end

    // first cycle of ramp zero only
    assign period_start = (ramp == '0) && (pre_cnt == '0);

endmodule

`default_nettype wire

// ==== hw/pwm_channel.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_channel import led_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [COLOR_W-1:0] rgb,
    input  wire logic [PWM_W-1:0]   ramp,
    input  wire logic               period_start,
    output logic                    led_r,
    output logic                    led_g,
    output logic                    led_b
);

    logic [COLOR_W-1:0] shadow;
    logic [COLOR_W-1:0] cur;

    // new color already applies to ramp step 0
    assign cur = period_start ? rgb : shadow;

    always_ff @(posedge clk) begin
        if (period_start) begin
            shadow <= rgb;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led_r <= 1'b0;
            led_g <= 1'b0;
            led_b <= 1'b0;
        end else begin
            led_r <= cur[23:16] > ramp;
            led_g <= cur[15:8] > ramp;
            led_b <= cur[7:0] > ramp;
        end
    end

endmodule

`default_nettype wire

// ==== hw/color_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module color_regfile import led_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic [CH_W-1:0]    channel,
    input  wire logic [FIELD_W-1:0] field,
    input  wire logic [NIB_W-1:0]   data,
    input  wire logic               valid,
    input  wire logic               color_next,
    output logic                    ack,
    output logic                    err,
    output logic [COLOR_W-1:0]      rgb0,
    output logic [COLOR_W-1:0]      rgb1,
    output logic [COLOR_W-1:0]      rgb2,
    output logic [COLOR_W-1:0]      rgb3
);

    logic [COLOR_W-1:0] rgb_ff [NUM_CH];
    logic [COLOR_W-1:0] rgb_nxt [NUM_CH];
    logic [CH_W-1:0]    ptr_ff [NUM_CH];
    logic [CH_W-1:0]    ptr_nxt [NUM_CH];
    logic               ack_ff;
    logic               ack_nxt;
    logic               err_ff;
    logic               err_nxt;
    logic               lock_ff;
    logic               lock_nxt;
    logic [4:0]         nib_lsb;
    logic               bad_field;
    logic [CH_W-1:0]    ptr_inc;

    function automatic logic [COLOR_W-1:0] preset_color(input logic [CH_W-1:0] idx);
        case (idx)
            2'd0:    return PRESET_RED;
            2'd1:    return PRESET_GREEN;
            2'd2:    return PRESET_BLUE;
            default: return PRESET_YELLOW;
        endcase
    endfunction

    // field code to nibble position
    always_comb begin
        bad_field = 1'b0;
        nib_lsb   = 5'd0;
        case (field)
            FIELD_RED_MSB: nib_lsb = 5'd20;
            FIELD_RED_LSB: nib_lsb = 5'd16;
            FIELD_GRN_MSB: nib_lsb = 5'd12;
            FIELD_GRN_LSB: nib_lsb = 5'd8;
            FIELD_BLU_MSB: nib_lsb = 5'd4;
            FIELD_BLU_LSB: nib_lsb = 5'd0;
            default:       bad_field = 1'b1;
        endcase
    end

    assign ptr_inc = ptr_ff[channel] + CH_W'(1);

    always_comb begin
        rgb_nxt  = rgb_ff;
        ptr_nxt  = ptr_ff;
        ack_nxt  = 1'b0;
        err_nxt  = 1'b0;
        lock_nxt = 1'b0;

        // one idle cycle after any request
        if (!lock_ff) begin
            if (valid) begin
                if (!bad_field) begin
                    rgb_nxt[channel][nib_lsb +: NIB_W] = data;
                end
                ack_nxt  = 1'b1;
                err_nxt  = bad_field;
                lock_nxt = 1'b1;
            end else if (color_next) begin
                // yellow wraps back to red
                ptr_nxt[channel] = ptr_inc;
                rgb_nxt[channel] = preset_color(ptr_inc);
                lock_nxt         = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_CH; i++) begin
                rgb_ff[i] <= preset_color(CH_W'(i));
                ptr_ff[i] <= CH_W'(i);
            end
            ack_ff  <= 1'b0;
            err_ff  <= 1'b0;
            lock_ff <= 1'b0;
        end else begin
            rgb_ff  <= rgb_nxt;
            ptr_ff  <= ptr_nxt;
            ack_ff  <= ack_nxt;
            err_ff  <= err_nxt;
            lock_ff <= lock_nxt;
        end
    end

    assign ack  = ack_ff;
    assign err  = err_ff;
    assign rgb0 = rgb_ff[0];
    assign rgb1 = rgb_ff[1];
    assign rgb2 = rgb_ff[2];
    assign rgb3 = rgb_ff[3];

endmodule

`default_nettype wire

// ==== hw/axil_cmd_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module axil_cmd_fsm import led_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [AXI_ADDR_W-1:0] awaddr,
    input  wire logic                  awvalid,
    output logic                       awready,
    input  wire logic [AXI_DATA_W-1:0] wdata,
    input  wire logic [AXI_STRB_W-1:0] wstrb,
    input  wire logic                  wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  wire logic                  bready,
    input  wire logic [AXI_ADDR_W-1:0] araddr,
    input  wire logic                  arvalid,
    output logic                       arready,
    output logic [AXI_DATA_W-1:0]      rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  wire logic                  rready,
    output logic [CH_W-1:0]            channel,
    output logic [FIELD_W-1:0]         field,
    output logic [NIB_W-1:0]           data,
    output logic                       valid,
    output logic                       color_next,
    input  wire logic                  ack,
    input  wire logic                  err,
    input  wire logic [COLOR_W-1:0]    rgb0,
    input  wire logic [COLOR_W-1:0]    rgb1,
    input  wire logic [COLOR_W-1:0]    rgb2,
    input  wire logic [COLOR_W-1:0]    rgb3
);

    typedef enum logic [2:0] {IDLE, REQ, WAIT_ACK, BRESP, RDATA} state_t;

    state_t                 state;
    state_t                 state_nxt;
    logic                   wr_hs;
    logic                   rd_hs;
    logic                   cmd_hit;
    logic                   step_hit;
    logic                   rd_hit;
    logic [COLOR_W-1:0]     rd_color;
    logic                   step_q;
    logic [CH_W-1:0]        ch_q;
    logic [FIELD_W-1:0]     field_q;
    logic [NIB_W-1:0]       data_q;
    logic [1:0]             bresp_q;
    logic [1:0]             rresp_q;
    logic [AXI_DATA_W-1:0]  rdata_q;

    // writes win over reads in idle
    assign awready = (state == IDLE);
    assign wready  = (state == IDLE);
    assign arready = (state == IDLE) && !awvalid && !wvalid;

    assign wr_hs = awready && awvalid && wvalid;
    assign rd_hs = arready && arvalid;

    // both byte lanes of the command must be strobed
    assign cmd_hit  = (awaddr == REG_CMD) && (wstrb[1:0] == 2'b11);
    assign step_hit = (awaddr == REG_STEP) && wstrb[0];

    // color window at 0x10..0x1c, word aligned
    assign rd_hit = (araddr[AXI_ADDR_W-1:4] == REG_COLOR0[AXI_ADDR_W-1:4])
                    && (araddr[1:0] == 2'b00);

    always_comb begin
        case (araddr[3:2])
            2'd0:    rd_color = rgb0;
            2'd1:    rd_color = rgb1;
            2'd2:    rd_color = rgb2;
            default: rd_color = rgb3;
        endcase
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (wr_hs) begin
                    state_nxt = (cmd_hit || step_hit) ? REQ : BRESP;
                end else if (rd_hs) begin
                    state_nxt = RDATA;
                end
            end
            REQ:      state_nxt = step_q ? BRESP : WAIT_ACK;
            WAIT_ACK: state_nxt = ack ? BRESP : WAIT_ACK;
            BRESP:    state_nxt = bready ? IDLE : BRESP;
            RDATA:    state_nxt = rready ? IDLE : RDATA;
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            step_q  <= step_hit;
            ch_q    <= step_hit ? wdata[1:0] : wdata[9:8];
            field_q <= wdata[7:4];
            data_q  <= wdata[3:0];
            bresp_q <= (cmd_hit || step_hit) ? RESP_OKAY : RESP_SLVERR;
        end
        // field write response comes back with the ack
        if (state == WAIT_ACK && ack) begin
            bresp_q <= err ? RESP_SLVERR : RESP_OKAY;
        end
        if (rd_hs) begin
            rdata_q <= rd_hit ? {{(AXI_DATA_W-COLOR_W){1'b0}}, rd_color} : '0;
            rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign bvalid = (state == BRESP);
    assign bresp  = bresp_q;
    assign rvalid = (state == RDATA);
    assign rdata  = rdata_q;
    assign rresp  = rresp_q;

    assign channel    = ch_q;
    assign field      = field_q;
    assign data       = data_q;
    assign valid      = (state == REQ) && !step_q;
    assign color_next = (state == REQ) && step_q;

endmodule

`default_nettype wire

// ==== hw/rgb_led_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rgb_led_top import led_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [AXI_ADDR_W-1:0] awaddr,
    input  wire logic                  awvalid,
    output logic                       awready,
    input  wire logic [AXI_DATA_W-1:0] wdata,
    input  wire logic [AXI_STRB_W-1:0] wstrb,
    input  wire logic                  wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  wire logic                  bready,
    input  wire logic [AXI_ADDR_W-1:0] araddr,
    input  wire logic                  arvalid,
    output logic                       arready,
    output logic [AXI_DATA_W-1:0]      rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  wire logic                  rready,
    output logic [NUM_CH-1:0]          led_r,
    output logic [NUM_CH-1:0]          led_g,
    output logic [NUM_CH-1:0]          led_b
);

    logic [CH_W-1:0]    channel;
    logic [FIELD_W-1:0] field;
    logic [NIB_W-1:0]   data;
    logic               valid;
    logic               color_next;
    logic               ack;
    logic               err;
    logic [COLOR_W-1:0] rgb [NUM_CH];
    logic [PWM_W-1:0]   ramp;
    logic               period_start;

    axil_cmd_fsm u_axil_cmd_fsm (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .channel    (channel),
        .field      (field),
        .data       (data),
        .valid      (valid),
        .color_next (color_next),
        .ack        (ack),
        .err        (err),
        .rgb0       (rgb[0]),
        .rgb1       (rgb[1]),
        .rgb2       (rgb[2]),
        .rgb3       (rgb[3])
    );

    color_regfile u_color_regfile (
        .clk        (clk),
        .rst        (rst),
        .channel    (channel),
        .field      (field),
        .data       (data),
        .valid      (valid),
        .color_next (color_next),
        .ack        (ack),
        .err        (err),
        .rgb0       (rgb[0]),
        .rgb1       (rgb[1]),
        .rgb2       (rgb[2]),
        .rgb3       (rgb[3])
    );

    pwm_timer u_pwm_timer (
        .clk          (clk),
        .rst          (rst),
        .ramp         (ramp),
        .period_start (period_start)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        pwm_channel u_pwm_channel (
            .clk          (clk),
            .rst          (rst),
            .rgb          (rgb[i]),
            .ramp         (ramp),
            .period_start (period_start),
            .led_r        (led_r[i]),
            .led_g        (led_g[i]),
            .led_b        (led_b[i])
        );
    end

endmodule

`default_nettype wire

// ==== tb/rgb_led_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module rgb_led_checker import led_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  bvalid,
    input  wire logic                  bready,
    input  wire logic [1:0]            bresp,
    input  wire logic                  rvalid,
    input  wire logic                  rready,
    input  wire logic [AXI_DATA_W-1:0] rdata,
    input  wire logic [1:0]            rresp
);

    int b_fail = 0;
    int r_fail = 0;
    int rst_fail = 0;
    int fail_cnt;

    assign fail_cnt = b_fail + r_fail + rst_fail;

    // write response held until bready
    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        $error("write response dropped or changed before it was accepted");
        b_fail++;
    end

    // read data held until rready
    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        $error("read response dropped or changed before it was accepted");
        r_fail++;
    end

    rst_quiet: assert property (@(posedge clk) rst |-> !bvalid && !rvalid)
    else begin
        $error("response valid while in reset");
        rst_fail++;
    end

endmodule

`default_nettype wire

// ==== tb/rgb_led_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rgb_led_tb import led_pkg::*; ();

    localparam int TIMEOUT = 1000;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    logic [NUM_CH-1:0]     led_r;
    logic [NUM_CH-1:0]     led_g;
    logic [NUM_CH-1:0]     led_b;

    // expected colors and ring pointers
    logic [COLOR_W-1:0] model [NUM_CH];
    int                 ptr [NUM_CH];
    int                 errors = 0;
    int                 checks = 0;
    int                 tests = 0;
    int                 err_mark = 0;

    always #50 clk = ~clk;

    rgb_led_top u_rgb_led_top (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .led_r   (led_r),
        .led_g   (led_g),
        .led_b   (led_b)
    );

    bind rgb_led_top rgb_led_checker u_rgb_led_checker (
        .clk    (clk),
        .rst    (rst),
        .bvalid (bvalid),
        .bready (bready),
        .bresp  (bresp),
        .rvalid (rvalid),
        .rready (rready),
        .rdata  (rdata),
        .rresp  (rresp)
    );

    // red, green, blue, yellow ring
    function automatic logic [COLOR_W-1:0] ring_color(input int idx);
        case (idx % NUM_CH)
            0:       return PRESET_RED;
            1:       return PRESET_GREEN;
            2:       return PRESET_BLUE;
            default: return PRESET_YELLOW;
        endcase
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic timeout_fail(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr,
                              input logic [AXI_DATA_W-1:0] wd,
                              input int stall, output logic [1:0] resp);
        int n;
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = wd;
        wstrb   = '1;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) timeout_fail("awready and wready");
        // taken on the rising edge in between
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) timeout_fail("bvalid");
        repeat (stall) begin
            @(negedge clk);
            expect_bit("bvalid", bvalid, 1'b1);
            expect_bit("awready", awready, 1'b0);
            expect_bit("wready", wready, 1'b0);
            expect_bit("arready", arready, 1'b0);
        end
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr, input int stall,
                             output logic [AXI_DATA_W-1:0] rd, output logic [1:0] resp);
        int n;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) timeout_fail("arready");
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) timeout_fail("rvalid");
        repeat (stall) begin
            @(negedge clk);
            expect_bit("rvalid", rvalid, 1'b1);
            expect_bit("arready", arready, 1'b0);
            expect_bit("awready", awready, 1'b0);
            expect_bit("wready", wready, 1'b0);
        end
        rd     = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic check_channel(input int ch);
        logic [AXI_DATA_W-1:0] rd;
        logic [1:0]            resp;
        axil_read(AXI_ADDR_W'(int'(REG_COLOR0) + 4 * ch), 0, rd, resp);
        expect_eq($sformatf("rdata ch%0d", ch), rd, 32'(model[ch]));
        expect_eq("rresp", 32'(resp), 32'(RESP_OKAY));
    endtask

    // field codes 3..8 map to nibbles from the top of the color down
    task automatic field_write(input int ch, input int fld, input int nib, input int stall);
        logic [1:0] resp;
        axil_write(REG_CMD, {22'd0, 2'(ch), 4'(fld), 4'(nib)}, stall, resp);
        if (fld >= 3 && fld <= 8) begin
            model[ch][(8 - fld) * 4 +: NIB_W] = 4'(nib);
            expect_eq("bresp", 32'(resp), 32'(RESP_OKAY));
        end else begin
            expect_eq("bresp", 32'(resp), 32'(RESP_SLVERR));
        end
    endtask

    task automatic step_channel(input int ch);
        logic [1:0] resp;
        axil_write(REG_STEP, {30'd0, 2'(ch)}, 0, resp);
        expect_eq("bresp", 32'(resp), 32'(RESP_OKAY));
        ptr[ch]   = (ptr[ch] + 1) % NUM_CH;
        model[ch] = ring_color(ptr[ch]);
        check_channel(ch);
    endtask

    task automatic set_color(input int ch, input logic [COLOR_W-1:0] color);
        for (int f = 3; f <= 8; f++) begin
            field_write(ch, f, int'(color[(8 - f) * 4 +: NIB_W]), 0);
        end
    endtask

    initial begin
        logic [AXI_DATA_W-1:0] rd;
        logic [1:0]            resp;
        int                    c;
        int                    cnt [3][NUM_CH];
        int                    total;

        void'($urandom(32'hd2d4_3978));
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = 0; i < NUM_CH; i++) begin
            model[i] = ring_color(i);
            ptr[i]   = i;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < NUM_CH; i++) begin
            check_channel(i);
        end
        finish_test("reset colors");

        repeat (16) begin
            c = $urandom % NUM_CH;
            field_write(c, 3 + $urandom % 6, $urandom % 16, 0);
            check_channel(c);
        end
        for (int i = 0; i < NUM_CH; i++) begin
            check_channel(i);
        end
        finish_test("field writes");

        c = $urandom % NUM_CH;
        field_write(c, 0, 4'ha, 0);
        field_write(c, 9, 4'h5, 0);
        check_channel(c);
        axil_write(8'h08, 32'h0000_0321, 0, resp);
        expect_eq("bresp", 32'(resp), 32'(RESP_SLVERR));
        for (int i = 0; i < NUM_CH; i++) begin
            check_channel(i);
        end
        axil_read(8'h20, 0, rd, resp);
        expect_eq("rresp", 32'(resp), 32'(RESP_SLVERR));
        expect_eq("rdata", rd, 32'h0);
        finish_test("bad field and offset");

        // channel 3 still points at yellow, so the first step wraps
        repeat (5) step_channel(3);
        field_write(3, 8, 4'h5, 0);
        check_channel(3);
        step_channel(3);
        repeat (3) step_channel($urandom % NUM_CH);
        finish_test("preset stepping");

        set_color(0, 24'hff_00_80);
        set_color(1, 24'h00_ff_01);
        set_color(2, 24'($urandom));
        set_color(3, 24'($urandom));
        repeat (2 * 256 * PWM_PRESCALE) @(negedge clk);
        for (int i = 0; i < NUM_CH; i++) begin
            cnt[0][i] = 0;
            cnt[1][i] = 0;
            cnt[2][i] = 0;
        end
        repeat (256 * PWM_PRESCALE) begin
            @(negedge clk);
            for (int i = 0; i < NUM_CH; i++) begin
                if (led_r[i]) cnt[0][i]++;
                if (led_g[i]) cnt[1][i]++;
                if (led_b[i]) cnt[2][i]++;
            end
        end
        for (int i = 0; i < NUM_CH; i++) begin
            expect_eq($sformatf("led_r[%0d] count", i), 32'(cnt[0][i]),
                      32'(model[i][23:16]) * PWM_PRESCALE);
            expect_eq($sformatf("led_g[%0d] count", i), 32'(cnt[1][i]),
                      32'(model[i][15:8]) * PWM_PRESCALE);
            expect_eq($sformatf("led_b[%0d] count", i), 32'(cnt[2][i]),
                      32'(model[i][7:0]) * PWM_PRESCALE);
        end
        finish_test("pwm duty");

        c = $urandom % NUM_CH;
        field_write(c, 5, $urandom % 16, 6);
        axil_read(AXI_ADDR_W'(int'(REG_COLOR0) + 4 * c), 6, rd, resp);
        expect_eq("rdata", rd, 32'(model[c]));
        expect_eq("rresp", 32'(resp), 32'(RESP_OKAY));
        field_write(c, 6, $urandom % 16, 0);
        check_channel(c);
        finish_test("back-pressure");

        total = errors + u_rgb_led_top.u_rgb_led_checker.fail_cnt;
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/led_pkg.sv
hw/pwm_timer.sv
hw/pwm_channel.sv
hw/color_regfile.sv
hw/axil_cmd_fsm.sv
hw/rgb_led_top.sv
tb/rgb_led_checker.sv
tb/rgb_led_tb.sv

// ==== Makefile ====
# Verilator build and run for the RGB LED subsystem

VERILATOR ?= verilator
TOP       ?= rgb_led_tb
RTL_TOP   ?= rgb_led_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
